/* verilog/lsu_pkg.sv */
// Shared widths, access size codes, page geometry and exception vectors for the load/store path
package lsu_pkg;

   // Data and virtual address width
   localparam int DW = 32;
   localparam int AW = 32;

   // Physical address covers the 8 KB data RAM
   localparam int PAW = 13;

   // 4 KB pages
   localparam int PAGE_BITS = 12;

   // Virtual page number, upper bits of the virtual address
   localparam int VPN_W = AW - PAGE_BITS;

   // Physical page number, only two pages of RAM
   localparam int PPN_W = PAW - PAGE_BITS;

   // Fully associative data TLB
   localparam int TLB_ENTRIES = 4;
   localparam int TLB_IDX_W = 2;

   // Access size codes on the command buses
   localparam logic [2:0] SIZE_BYTE = 3'd1;
   localparam logic [2:0] SIZE_HALF = 3'd2;
   localparam logic [2:0] SIZE_WORD = 3'd3;

   // Exception vector width
   localparam int VECT_DW = 8;

   // Data TLB miss
   localparam logic [VECT_DW-1:0] EDTM_VECTOR = 8'h14;

   // Data page fault, store to a read-only page
   localparam logic [VECT_DW-1:0] EDPF_VECTOR = 8'h18;

   // Exception target is a word address
   localparam int EXP_TGT_W = AW - 2;

endpackage

/* verilog/mem_unit.sv */
// Memory unit: forms the address, issues one bus command at a time and extends load data
`timescale 1ns/1ps

module mem_unit (
   input  logic                           clk,
   input  logic                           rst_n,
   // Operation issue from execute
   input  logic                           op_valid,
   output logic                           op_ready,
   input  logic [lsu_pkg::DW-1:0]         operand_1,
   input  logic [lsu_pkg::DW-1:0]         operand_2,
   input  logic [lsu_pkg::DW-1:0]         operand_3,
   input  logic                           op_load,
   input  logic                           op_store,
   input  logic                           op_sign_ext,
   input  logic [2:0]                     op_load_size,
   input  logic [2:0]                     op_store_size,
   // Write-back
   output logic                           wb_valid,
   input  logic                           wb_ready,
   output logic [lsu_pkg::DW-1:0]         load_data,
   // Exception and flush
   input  logic                           flush_ack,
   output logic                           exp_taken,
   output logic [lsu_pkg::EXP_TGT_W-1:0]  exp_tgt,
   output logic [lsu_pkg::AW-1:0]         lsa,
   // Virtual command bus toward the TLB
   output logic                           vcmd_valid,
   input  logic                           vcmd_ready,
   output logic [lsu_pkg::AW-1:0]         vcmd_addr,
   output logic [2:0]                     vcmd_size,
   output logic                           vcmd_we,
   output logic [lsu_pkg::DW-1:0]         vcmd_din,
   // Response from the data RAM
   input  logic                           rsp_valid,
   output logic                           rsp_ready,
   input  logic [lsu_pkg::DW-1:0]         rsp_data,
   // Translation faults
   input  logic                           exp_tlb_miss,
   input  logic                           exp_page_fault
);
   import lsu_pkg::*;

   logic                 mem_op;
   logic                 hds_vcmd;
   logic                 hds_wb;
   logic                 hds_exp;
   logic                 exp_raised;
   logic                 pending_r;
   logic [VECT_DW-1:0]   exp_vector;

   // Load or store, anything else passes straight through
   assign mem_op = op_load | op_store;

   // Handshakes
   assign hds_vcmd = vcmd_valid & vcmd_ready;
   assign hds_wb   = wb_valid & wb_ready;

   // Virtual address, also reported for faults
   assign lsa = operand_1 + operand_2;

   // Bus command straight from the operands
   assign vcmd_addr = lsa;
   assign vcmd_we   = op_store;
   assign vcmd_din  = operand_3;

   // Size follows the kind of access
   always_comb begin
      if (op_store) begin
         vcmd_size = op_store_size;
      end else if (op_load) begin
         vcmd_size = op_load_size;
      end else begin
         vcmd_size = 3'd0;
      end
   end

   // Either fault from the TLB
   assign exp_raised = exp_tlb_miss | exp_page_fault;

   // Faults only belong to us while an access is outstanding
   assign exp_taken = pending_r & exp_raised;
   assign hds_exp   = exp_taken & flush_ack;

   // Pending FSM
   // Set at the command handshake, cleared by write-back or flush
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending_r <= 1'b0;
      end else if (!pending_r && hds_vcmd) begin
         pending_r <= 1'b1;
      end else if (pending_r && (hds_wb || hds_exp)) begin
         pending_r <= 1'b0;
      end
   end

   // Only one command outstanding
   assign vcmd_valid = op_valid & mem_op & ~pending_r;

   // Operands held until result accepted or fault taken
   assign op_ready = ~mem_op | hds_wb | exp_taken;

   // Response goes straight on to write-back
   assign wb_valid  = rsp_valid;
   assign rsp_ready = wb_ready;

   // Load extension
   // RAM already returns the bytes in the low lanes
   always_comb begin
      case (op_load_size)
         SIZE_BYTE: load_data = {{(DW-8){op_sign_ext & rsp_data[7]}}, rsp_data[7:0]};
         SIZE_HALF: load_data = {{(DW-16){op_sign_ext & rsp_data[15]}}, rsp_data[15:0]};
         default:   load_data = rsp_data;
      endcase
   end

   // Vector select, the TLB never raises both
   always_comb begin
      exp_vector = '0;
      if (exp_tlb_miss) begin
         exp_vector = EDTM_VECTOR;
      end else if (exp_page_fault) begin
         exp_vector = EDPF_VECTOR;
      end
   end

   // Target as a word address
   assign exp_tgt = {{(EXP_TGT_W-VECT_DW+2){1'b0}}, exp_vector[VECT_DW-1:2]};

   // Responses and faults only arrive for the access that is outstanding
   a_rsp_outstanding: assert property (
      @(posedge clk) disable iff (!rst_n)
      (rsp_valid || exp_raised) |-> pending_r
   ) else $error("mem_unit: response or fault without an outstanding access");

endmodule

/* verilog/dtlb.sv */
// Four-entry data TLB: translates one virtual command into a registered physical command
`timescale 1ns/1ps

module dtlb (
   input  logic                           clk,
   input  logic                           rst_n,
   // Fill port from the testbench side
   input  logic                           tlb_we,
   input  logic [lsu_pkg::TLB_IDX_W-1:0]  tlb_idx,
   input  logic [lsu_pkg::VPN_W-1:0]      tlb_vpn,
   input  logic [lsu_pkg::PPN_W-1:0]      tlb_ppn,
   input  logic                           tlb_writable,
   // Virtual command in
   input  logic                           vcmd_valid,
   output logic                           vcmd_ready,
   input  logic [lsu_pkg::AW-1:0]         vcmd_addr,
   input  logic [2:0]                     vcmd_size,
   input  logic                           vcmd_we,
   input  logic [lsu_pkg::DW-1:0]         vcmd_din,
   // Physical command out
   output logic                           pcmd_valid,
   input  logic                           pcmd_ready,
   output logic [lsu_pkg::PAW-1:0]        pcmd_addr,
   output logic [2:0]                     pcmd_size,
   output logic                           pcmd_we,
   output logic [lsu_pkg::DW-1:0]         pcmd_din,
   // Faults and flush
   output logic                           exp_tlb_miss,
   output logic                           exp_page_fault,
   input  logic                           exp_taken,
   input  logic                           flush_ack
);
   import lsu_pkg::*;

   // Entry storage
   logic [TLB_ENTRIES-1:0] ent_valid;
   logic [TLB_ENTRIES-1:0] ent_writable;
   logic [VPN_W-1:0]       ent_vpn [TLB_ENTRIES];
   logic [PPN_W-1:0]       ent_ppn [TLB_ENTRIES];

   // Lookup
   logic [VPN_W-1:0]       req_vpn;
   logic [TLB_ENTRIES-1:0] hit_vec;
   logic                   hit;
   logic [PPN_W-1:0]       hit_ppn;
   logic                   hit_writable;

   logic                   hds_vcmd;
   logic                   hds_pcmd;
   logic                   hds_exp;

   // Entries become valid on fill, no invalidate
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ent_valid <= '0;
      end else if (tlb_we) begin
         ent_valid[tlb_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tlb_we) begin
         ent_vpn[tlb_idx]      <= tlb_vpn;
         ent_ppn[tlb_idx]      <= tlb_ppn;
         ent_writable[tlb_idx] <= tlb_writable;
      end
   end

   assign req_vpn = vcmd_addr[AW-1:PAGE_BITS];

   // Compare against all entries at once
   // At most one entry is expected to match
   always_comb begin
      hit_ppn      = '0;
      hit_writable = 1'b0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         hit_vec[i] = ent_valid[i] && (ent_vpn[i] == req_vpn);
         if (hit_vec[i]) begin
            hit_ppn      = hit_ppn | ent_ppn[i];
            hit_writable = hit_writable | ent_writable[i];
         end
      end
   end

   assign hit = |hit_vec;

   // Idle only when nothing is held
   assign vcmd_ready = ~(pcmd_valid | exp_tlb_miss | exp_page_fault);

   assign hds_vcmd = vcmd_valid & vcmd_ready;
   assign hds_pcmd = pcmd_valid & pcmd_ready;
   assign hds_exp  = exp_taken & flush_ack;

   // Outcome of a lookup: command, miss or write fault
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pcmd_valid     <= 1'b0;
         exp_tlb_miss   <= 1'b0;
         exp_page_fault <= 1'b0;
      end else begin
         if (hds_pcmd) begin
            pcmd_valid <= 1'b0;
         end
         // Flags held until the flush handshake
         if (hds_exp) begin
            exp_tlb_miss   <= 1'b0;
            exp_page_fault <= 1'b0;
         end
         if (hds_vcmd) begin
            if (!hit) begin
               exp_tlb_miss <= 1'b1;
            end else if (vcmd_we && !hit_writable) begin
               exp_page_fault <= 1'b1;
            end else begin
               pcmd_valid <= 1'b1;
            end
         end
      end
   end

   // Translated command, page offset kept as is
   always_ff @(posedge clk) begin
      if (hds_vcmd) begin
         pcmd_addr <= {hit_ppn, vcmd_addr[PAGE_BITS-1:0]};
         pcmd_size <= vcmd_size;
         pcmd_we   <= vcmd_we;
         pcmd_din  <= vcmd_din;
      end
   end

   // One fault kind at a time
   a_fault_mutex: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(exp_tlb_miss && exp_page_fault)
   ) else $error("dtlb: miss and page fault raised together");

   // Fill must not map one virtual page into two entries
   a_single_hit: assert property (
      @(posedge clk) disable iff (!rst_n)
      hds_vcmd |-> $onehot0(hit_vec)
   ) else $error("dtlb: virtual page matches more than one entry");

endmodule

/* verilog/data_ram.sv */
// Byte-lane data RAM of 8 KB with a registered response held under back-pressure
`timescale 1ns/1ps

module data_ram (
   input  logic                     clk,
   input  logic                     rst_n,
   // Physical command in
   input  logic                     pcmd_valid,
   output logic                     pcmd_ready,
   input  logic [lsu_pkg::PAW-1:0]  pcmd_addr,
   input  logic [2:0]               pcmd_size,
   input  logic                     pcmd_we,
   input  logic [lsu_pkg::DW-1:0]   pcmd_din,
   // Response out
   output logic                     rsp_valid,
   input  logic                     rsp_ready,
   output logic [lsu_pkg::DW-1:0]   rsp_data
);
   import lsu_pkg::*;

   // One word per row, written by byte lane
   logic [DW-1:0]   mem [2**(PAW-2)];

   logic [PAW-3:0]  widx;
   logic [1:0]      boff;
   logic [DW/8-1:0] be;
   logic [DW-1:0]   wdata;
   logic [DW-1:0]   rd_word;
   logic [DW-1:0]   rd_shift;
   logic [DW-1:0]   rd_data;
   logic            hds_cmd;
   logic            hds_rsp;

   assign widx = pcmd_addr[PAW-1:2];
   assign boff = pcmd_addr[1:0];

   // No new command while a response waits
   assign pcmd_ready = ~rsp_valid;
   assign hds_cmd    = pcmd_valid & pcmd_ready;
   assign hds_rsp    = rsp_valid & rsp_ready;

   // Lane enables and replicated store data
   always_comb begin
      case (pcmd_size)
         SIZE_BYTE: begin
            be    = 4'b0001 << boff;
            wdata = {4{pcmd_din[7:0]}};
         end
         SIZE_HALF: begin
            be    = 4'b0011 << boff;
            wdata = {2{pcmd_din[15:0]}};
         end
         default: begin
            be    = 4'b1111;
            wdata = pcmd_din;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (hds_cmd && pcmd_we) begin
         for (int i = 0; i < DW/8; i++) begin
            if (be[i]) begin
               mem[widx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
   end

   // Addressed bytes moved down to lane 0, rest cleared
   assign rd_word  = mem[widx];
   assign rd_shift = rd_word >> {boff, 3'b000};

   always_comb begin
      case (pcmd_size)
         SIZE_BYTE: rd_data = {{(DW-8){1'b0}}, rd_shift[7:0]};
         SIZE_HALF: rd_data = {{(DW-16){1'b0}}, rd_shift[15:0]};
         default:   rd_data = rd_shift;
      endcase
   end

   // Stores also answer, data is don't care
   always_ff @(posedge clk) begin
      if (hds_cmd) begin
         rsp_data <= rd_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (hds_cmd) begin
         rsp_valid <= 1'b1;
      end else if (hds_rsp) begin
         rsp_valid <= 1'b0;
      end
   end

   // A stalled response keeps its data and blocks new commands
   a_rsp_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && !hds_cmd
   ) else $error("data_ram: response changed under back-pressure");

endmodule

/* verilog/lsu_top.sv */
// Load/store path top: memory unit, data TLB and data RAM joined by valid/ready links
`timescale 1ns/1ps

module lsu_top (
   input  logic                           clk,
   input  logic                           rst_n,
   // Operation issue
   input  logic                           op_valid,
   output logic                           op_ready,
   input  logic [lsu_pkg::DW-1:0]         operand_1,
   input  logic [lsu_pkg::DW-1:0]         operand_2,
   input  logic [lsu_pkg::DW-1:0]         operand_3,
   input  logic                           op_load,
   input  logic                           op_store,
   input  logic                           op_sign_ext,
   input  logic [2:0]                     op_load_size,
   input  logic [2:0]                     op_store_size,
   // Write-back
   output logic                           wb_valid,
   input  logic                           wb_ready,
   output logic [lsu_pkg::DW-1:0]         load_data,
   // Exception and flush
   input  logic                           flush_ack,
   output logic                           exp_taken,
   output logic [lsu_pkg::EXP_TGT_W-1:0]  exp_tgt,
   output logic [lsu_pkg::AW-1:0]         lsa,
   // TLB fill
   input  logic                           tlb_we,
   input  logic [lsu_pkg::TLB_IDX_W-1:0]  tlb_idx,
   input  logic [lsu_pkg::VPN_W-1:0]      tlb_vpn,
   input  logic [lsu_pkg::PPN_W-1:0]      tlb_ppn,
   input  logic                           tlb_writable
);
   import lsu_pkg::*;

   // Virtual bus
   logic               vcmd_valid;
   logic               vcmd_ready;
   logic [AW-1:0]      vcmd_addr;
   logic [2:0]         vcmd_size;
   logic               vcmd_we;
   logic [DW-1:0]      vcmd_din;

   // Physical bus
   logic               pcmd_valid;
   logic               pcmd_ready;
   logic [PAW-1:0]     pcmd_addr;
   logic [2:0]         pcmd_size;
   logic               pcmd_we;
   logic [DW-1:0]      pcmd_din;

   // RAM response
   logic               rsp_valid;
   logic               rsp_ready;
   logic [DW-1:0]      rsp_data;

   // Translation faults
   logic               exp_tlb_miss;
   logic               exp_page_fault;

   mem_unit mem_unit_i (
      .clk, .rst_n,
      .op_valid, .op_ready, .operand_1, .operand_2, .operand_3,
      .op_load, .op_store, .op_sign_ext, .op_load_size, .op_store_size,
      .wb_valid, .wb_ready, .load_data,
      .flush_ack, .exp_taken, .exp_tgt, .lsa,
      .vcmd_valid, .vcmd_ready, .vcmd_addr, .vcmd_size, .vcmd_we, .vcmd_din,
      .rsp_valid, .rsp_ready, .rsp_data,
      .exp_tlb_miss, .exp_page_fault
   );

   dtlb dtlb_i (
      .clk, .rst_n,
      .tlb_we, .tlb_idx, .tlb_vpn, .tlb_ppn, .tlb_writable,
      .vcmd_valid, .vcmd_ready, .vcmd_addr, .vcmd_size, .vcmd_we, .vcmd_din,
      .pcmd_valid, .pcmd_ready, .pcmd_addr, .pcmd_size, .pcmd_we, .pcmd_din,
      .exp_tlb_miss, .exp_page_fault, .exp_taken, .flush_ack
   );

   data_ram data_ram_i (
      .clk, .rst_n,
      .pcmd_valid, .pcmd_ready, .pcmd_addr, .pcmd_size, .pcmd_we, .pcmd_din,
      .rsp_valid, .rsp_ready, .rsp_data
   );

endmodule

/* tb/tb_clock.sv */
// Testbench clock and reset source, 40 ns period with reset held low for the first 5 cycles
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);
   localparam int RST_CYCLES = 5;

   // 20 ns half period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* tb/lsu_tb.sv */
// Testbench for lsu_top: fills the TLB, runs a table of loads and stores, checks against a byte model
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int N_ROWS = 20;
   localparam int TIMEOUT_CYCLES = N_ROWS * 20 + 100;
   localparam bit LD = 1'b0;
   localparam bit ST = 1'b1;
   // Expected exception targets, vector as a word address
   localparam logic [31:0] MISS_TGT  = {24'h0, EDTM_VECTOR} >> 2;
   localparam logic [31:0] FAULT_TGT = {24'h0, EDPF_VECTOR} >> 2;

   logic clk;
   logic rst_n;
   logic op_valid, op_ready, op_load, op_store, op_sign_ext;
   logic [DW-1:0] operand_1, operand_2, operand_3, load_data;
   logic [2:0] op_load_size, op_store_size;
   logic wb_valid, wb_ready, flush_ack, exp_taken;
   logic [EXP_TGT_W-1:0] exp_tgt;
   logic [AW-1:0] lsa;
   logic tlb_we, tlb_writable;
   logic [TLB_IDX_W-1:0] tlb_idx;
   logic [VPN_W-1:0] tlb_vpn;
   logic [PPN_W-1:0] tlb_ppn;

   // Stimulus table, one entry per operation
   logic        row_st   [N_ROWS];
   logic [2:0]  row_size [N_ROWS];
   logic        row_sgn  [N_ROWS];
   logic [31:0] row_op1  [N_ROWS];
   logic [31:0] row_op2  [N_ROWS];
   logic [31:0] row_din  [N_ROWS];
   logic [31:0] row_tgt  [N_ROWS];
   logic        row_bp   [N_ROWS];
   int          n_rows = 0;

   // Byte model of the physical RAM
   logic [7:0]  model_mem [2**PAW];

   int mismatch_cnt = 0;
   int fail_cnt = 0;
   int cycle_cnt = 0;

   tb_clock clock_gen_i (.clk, .rst_n);

   lsu_top lsu_top_i (
      .clk, .rst_n,
      .op_valid, .op_ready, .operand_1, .operand_2, .operand_3,
      .op_load, .op_store, .op_sign_ext, .op_load_size, .op_store_size,
      .wb_valid, .wb_ready, .load_data,
      .flush_ack, .exp_taken, .exp_tgt, .lsa,
      .tlb_we, .tlb_idx, .tlb_vpn, .tlb_ppn, .tlb_writable
   );

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         mismatch_cnt++;
         $display("MISMATCH %s: got %h, expected %h", name, got, want);
      end
   endtask

   task automatic add_row(input logic st, input logic [2:0] size, input logic sgn,
                          input logic [31:0] op1, input logic [31:0] op2,
                          input logic [31:0] din, input logic [31:0] tgt, input logic bp);
      row_st[n_rows]   = st;
      row_size[n_rows] = size;
      row_sgn[n_rows]  = sgn;
      row_op1[n_rows]  = op1;
      row_op2[n_rows]  = op2;
      row_din[n_rows]  = din;
      row_tgt[n_rows]  = tgt;
      row_bp[n_rows]   = bp;
      n_rows++;
   endtask

   // Every mapped page has vpn bit 0 equal to its ppn
   function automatic logic [PAW-1:0] phys_addr(input logic [31:0] va);
      return va[PAW-1:0];
   endfunction

   function automatic logic [31:0] model_load(input logic [31:0] va, input logic [2:0] size,
                                              input logic sgn);
      logic [PAW-1:0] pa;
      logic [31:0]    w;
      pa = phys_addr(va);
      case (size)
         SIZE_BYTE: w = {{24{sgn & model_mem[pa][7]}}, model_mem[pa]};
         SIZE_HALF: w = {{16{sgn & model_mem[pa+1][7]}}, model_mem[pa+1], model_mem[pa]};
         default:   w = {model_mem[pa+3], model_mem[pa+2], model_mem[pa+1], model_mem[pa]};
      endcase
      return w;
   endfunction

   task automatic model_store(input logic [31:0] va, input logic [2:0] size, input logic [31:0] d);
      logic [PAW-1:0] pa;
      int             nbytes;
      pa = phys_addr(va);
      nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
      for (int i = 0; i < nbytes; i++) begin
         model_mem[pa + i] = d[i*8 +: 8];
      end
   endtask

   task automatic fill_entry(input int idx, input logic [19:0] vpn, input logic ppn,
                             input logic wr);
      @(negedge clk);
      tlb_we       = 1'b1;
      tlb_idx      = idx;
      tlb_vpn      = vpn;
      tlb_ppn      = ppn;
      tlb_writable = wr;
   endtask

   // One operation from issue to write-back or flush
   task automatic run_row(input int r);
      logic [31:0] want;
      logic        fault;
      logic        seen;
      int          waited;
      fault  = (row_tgt[r] != 0);
      want   = row_st[r] ? 32'h0 : model_load(row_op1[r] + row_op2[r], row_size[r], row_sgn[r]);
      waited = 0;
      seen   = 1'b0;
      @(negedge clk);
      flush_ack     = 1'b0;
      op_valid      = 1'b1;
      op_load       = !row_st[r];
      op_store      = row_st[r];
      op_sign_ext   = row_sgn[r];
      op_load_size  = row_size[r];
      op_store_size = row_size[r];
      operand_1     = row_op1[r];
      operand_2     = row_op2[r];
      operand_3     = row_din[r];
      wb_ready      = !row_bp[r];
      // Back-pressure rows release wb_ready after three cycles
      while (!seen) begin
         @(negedge clk);
         if (waited >= 3) begin
            wb_ready = 1'b1;
         end
         // Sample just after the drive so op_ready already follows wb_ready
         #1;
         seen = op_ready;
         if (!seen) begin
            waited++;
         end
      end
      if (row_bp[r] && !fault && waited < 3) begin
         fail_cnt++;
         $display("Row %0d: op_ready rose while wb_ready was still held low", r);
      end
      check_val("exp_taken", exp_taken, fault);
      check_val("exp_tgt", exp_tgt, row_tgt[r]);
      if (fault) begin
         check_val("lsa", lsa, row_op1[r] + row_op2[r]);
         // Flush completes at the next edge
         flush_ack = 1'b1;
      end else begin
         check_val("wb_valid", wb_valid, 1'b1);
         if (row_st[r]) begin
            model_store(row_op1[r] + row_op2[r], row_size[r], row_din[r]);
         end else begin
            check_val("load_data", load_data, want);
         end
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // Run limit from the table length
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         fail_cnt++;
         finish_run();
      end
   end

   initial begin
      op_valid = 1'b0;
      op_load = 1'b0;
      op_store = 1'b0;
      op_sign_ext = 1'b0;
      op_load_size = SIZE_WORD;
      op_store_size = SIZE_WORD;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      wb_ready = 1'b1;
      flush_ack = 1'b0;
      tlb_we = 1'b0;
      tlb_idx = '0;
      tlb_vpn = '0;
      tlb_ppn = '0;
      tlb_writable = 1'b0;

      //      kind size       sgn  operand_1     operand_2  store data    exp target  bp
      add_row(ST, SIZE_WORD, 0, 32'h1000_0000, 32'h10, 32'hcafe_f00d, 32'h0,     0);
      add_row(LD, SIZE_WORD, 0, 32'h1000_0000, 32'h10, 32'h0,         32'h0,     0);
      add_row(ST, SIZE_WORD, 0, 32'h1000_1000, 32'h20, 32'h8000_7f81, 32'h0,     0);
      // Sign and zero extension, top bit set and clear
      add_row(LD, SIZE_BYTE, 1, 32'h1000_1000, 32'h20, 32'h0,         32'h0,     0);
      add_row(LD, SIZE_BYTE, 0, 32'h1000_1000, 32'h20, 32'h0,         32'h0,     0);
      add_row(LD, SIZE_BYTE, 1, 32'h1000_1000, 32'h21, 32'h0,         32'h0,     0);
      add_row(LD, SIZE_HALF, 1, 32'h1000_1000, 32'h22, 32'h0,         32'h0,     0);
      add_row(LD, SIZE_HALF, 0, 32'h1000_1000, 32'h22, 32'h0,         32'h0,     0);
      add_row(LD, SIZE_HALF, 1, 32'h1000_1000, 32'h20, 32'h0,         32'h0,     0);
      // Sub-word stores leave neighbouring bytes alone
      add_row(ST, SIZE_BYTE, 0, 32'h1000_0010, 32'h1,  32'haaaa_aa55, 32'h0,     0);
      add_row(ST, SIZE_HALF, 0, 32'h1000_0010, 32'h2,  32'hdead_1234, 32'h0,     0);
      add_row(LD, SIZE_WORD, 0, 32'h1000_0010, 32'h0,  32'h0,         32'h0,     0);
      // Unmapped page, then a normal row after the flush
      add_row(LD, SIZE_WORD, 0, 32'h3000_0000, 32'h0,  32'h0,         MISS_TGT,  0);
      add_row(LD, SIZE_WORD, 0, 32'h1000_0000, 32'h10, 32'h0,         32'h0,     1);
      // Store to read-only alias faults and leaves memory unchanged
      add_row(ST, SIZE_WORD, 0, 32'h2000_0000, 32'h10, 32'h1111_2222, FAULT_TGT, 0);
      add_row(LD, SIZE_WORD, 0, 32'h2000_0000, 32'h10, 32'h0,         32'h0,     1);
      add_row(ST, SIZE_WORD, 0, 32'h4000_0100, 32'h0,  32'h3333_4444, MISS_TGT,  0);
      add_row(ST, SIZE_WORD, 0, 32'h1000_1000, 32'h40, 32'h0bad_beef, 32'h0,     1);
      add_row(LD, SIZE_WORD, 0, 32'h2000_1000, 32'h40, 32'h0,         32'h0,     1);
      add_row(LD, SIZE_BYTE, 1, 32'h2000_1000, 32'h43, 32'h0,         32'h0,     0);

      wait (rst_n === 1'b1);
      // Two writable pages and their read-only aliases
      fill_entry(0, 20'h10000, 1'b0, 1'b1);
      fill_entry(1, 20'h10001, 1'b1, 1'b1);
      fill_entry(2, 20'h20000, 1'b0, 1'b0);
      fill_entry(3, 20'h20001, 1'b1, 1'b0);
      @(negedge clk);
      tlb_we = 1'b0;

      if (n_rows != N_ROWS) begin
         fail_cnt++;
         $display("Row table holds %0d rows instead of %0d", n_rows, N_ROWS);
      end
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end

      @(negedge clk);
      op_valid = 1'b0;
      flush_ack = 1'b0;
      repeat (2) @(negedge clk);
      finish_run();
   end

endmodule

/* all.f */
verilog/lsu_pkg.sv
verilog/mem_unit.sv
verilog/dtlb.sv
verilog/data_ram.sv
verilog/lsu_top.sv
tb/tb_clock.sv
tb/lsu_tb.sv
